/* hdl/capturePkg.sv */
`default_nettype none
// ======================================
// Widths and layout shared by all RTL
// fifoDepth must be a power of two, >= 4
// ======================================
package capturePkg;

    // ======================================
    // Data path
    // ======================================
    localparam int dataWidth = 16;                          // Captured word and bus data

    // ======================================
    // Asynchronous FIFO
    // ======================================
    localparam int fifoDepth = 8;                           // Entries per channel FIFO
    localparam int fifoPtrWidth = $clog2(fifoDepth);        // Pointer bits, no wrap bit

    // ======================================
    // Shared RAM and regions
    // ======================================
    localparam int ramAddrWidth = 6;                        // 64 words in total
    localparam int regionWords = 32;                        // Words per channel region
    localparam int regionOffWidth = $clog2(regionWords);    // Offset inside a region

    // Channel k owns k*regionWords up to k*regionWords+regionWords-1

    // ======================================
    // Bus masters
    // ======================================
    localparam int numMasters = 3;                          // Chan 0, chan 1, host
    localparam int masterIdxWidth = $clog2(numMasters);     // Index of a master

endpackage

`default_nettype wire

/* hdl/wbBus.sv */
`default_nettype none
// ======================================
// Wishbone classic, single transfers only
// ======================================
interface wbBus;
    import capturePkg::*;

    logic                    cyc;   // Bus cycle in progress
    logic                    stb;   // Transfer request
    logic                    we;    // Write enable
    logic [ramAddrWidth-1:0] adr;   // Word address
    logic [dataWidth-1:0]    datW;  // Write data
    logic [dataWidth-1:0]    datR;  // Read data, valid with ack
    logic                    ack;   // One cycle per transfer

    // Master holds adr, datW and we until ack
    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output datW,
        input  datR,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  datW,
        output datR,
        output ack
    );

endinterface

`default_nettype wire

/* hdl/asyncFifo.sv */
`default_nettype none
// ======================================
// Gray pointer FIFO, depth from capturePkg
// Status flags lag two cycles of own clock
// ======================================
module asyncFifo (
    input  logic                             wclk,      // Producer clock
    input  logic                             rclk,      // Consumer clock
    input  logic                             arok,      // Async reset, active low
    input  logic                             push,      // Write request
    input  logic [capturePkg::dataWidth-1:0] pushData,  // Word to store
    output logic                             pushOk,    // Space available
    input  logic                             pop,       // Read request
    output logic [capturePkg::dataWidth-1:0] popData,   // Head word
    output logic                             popOk      // Word available
);
    import capturePkg::*;

    logic [dataWidth-1:0]    mem [fifoDepth];   // Storage

    logic [fifoPtrWidth-1:0] rBin;              // Read pointer, binary
    logic [fifoPtrWidth-1:0] rGray;             // Read pointer, gray
    logic [fifoPtrWidth-1:0] rBinNext;
    logic [1:0]              rdReady;           // Read OK re-timing stages
    logic                    rdClrN;            // Clears read stages

    logic [fifoPtrWidth-1:0] wBin;              // Write pointer, binary
    logic [fifoPtrWidth-1:0] wGray;             // Delayed gray, seen by read side
    logic [fifoPtrWidth-1:0] wGrayNext;         // Gray of next free slot
    logic [fifoPtrWidth-1:0] wBinNext;
    logic [1:0]              wrBlock;           // Inverted write OK stages

    logic                    dir;               // Set when write nears read
    logic                    rdOkAsync;         // Not empty, unsynchronized
    logic                    wrOkAsync;         // Not full, unsynchronized
    logic                    dirSet;
    logic                    dirClr;

    // ======================================
    // Read side
    // ======================================
    assign rBinNext = rBin + 1'b1;

    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            rBin  <= '0;
            rGray <= '0;
        end else if (pop && popOk) begin
            rBin  <= rBinNext;
            rGray <= (rBinNext >> 1) ^ rBinNext;    // Binary to gray
        end
    end

    assign rdClrN = arok && rdOkAsync;              // Empty drops popOk at once

    always_ff @(posedge rclk or negedge rdClrN) begin
        if (!rdClrN) rdReady <= 2'b00;
        else         rdReady <= {rdReady[0], 1'b1};  // Two stages to rise
    end

    assign popData = mem[rBin];                     // Head word, always shown
    assign popOk   = rdReady[1];

    // ======================================
    // Write side
    // ======================================
    assign wBinNext = wBin + 1'b1;

    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            wBin      <= '0;
            wGray     <= '0;
            wGrayNext <= '0;
        end else begin
            wGray <= wGrayNext;                     // Word settles before read sees it
            if (push && pushOk) begin
                wBin      <= wBinNext;
                wGrayNext <= (wBinNext >> 1) ^ wBinNext;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (push && pushOk) mem[wBin] <= pushData;
    end

    // Full sets the stages at once, reset leaves write OK
    always_ff @(posedge wclk or negedge arok or negedge wrOkAsync) begin
        if (!arok)           wrBlock <= 2'b00;
        else if (!wrOkAsync) wrBlock <= 2'b11;
        else                 wrBlock <= {wrBlock[0], 1'b0};
    end

    assign pushOk = !wrBlock[1];

    // ======================================
    // Async status from gray quadrants
    // ======================================
    assign rdOkAsync = (rGray != wGray) || dir;
    assign wrOkAsync = (rGray != wGrayNext) || !dir;

    assign dirSet = (rGray[fifoPtrWidth-1] == wGrayNext[fifoPtrWidth-2])
                 && (rGray[fifoPtrWidth-2] != wGrayNext[fifoPtrWidth-1]);
    assign dirClr = ((rGray[fifoPtrWidth-1] != wGrayNext[fifoPtrWidth-2])
                 && (rGray[fifoPtrWidth-2] == wGrayNext[fifoPtrWidth-1])) || !arok;

    always_ff @(posedge dirSet or posedge dirClr) begin
        if (dirClr) dir <= 1'b0;                    // Write fell behind, or reset
        else        dir <= 1'b1;                    // Write catching up on read
    end

endmodule

`default_nettype wire

/* hdl/channelDrain.sv */
`default_nettype none
// ======================================
// One word in flight, region by channelId
// ======================================
module channelDrain #(
    parameter int channelId = 0                         // 0 or 1
) (
    input  logic                             rclk,      // Bus clock
    input  logic                             arok,      // Async reset, active low
    input  logic [capturePkg::dataWidth-1:0] popData,   // FIFO head word
    input  logic                             popOk,     // FIFO not empty
    output logic                             pop,       // Take head word
    wbBus.master                             bus        // Write port to arbiter
);
    import capturePkg::*;

    logic                      busy;        // Idle or busy
    logic [regionOffWidth-1:0] offset;      // Next slot in region
    logic [dataWidth-1:0]      wordHold;    // Word being written
    logic [ramAddrWidth-1:0]   regionBase;  // First word of region

    assign regionBase = ramAddrWidth'(channelId * regionWords);

    // Pop only when nothing is held
    assign pop = !busy && popOk;

    // ======================================
    // Two-state control
    // ======================================
    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            busy   <= 1'b0;
            offset <= '0;
        end else if (!busy) begin
            busy <= popOk;                  // Popped this edge
        end else if (bus.ack) begin
            busy   <= 1'b0;
            offset <= offset + 1'b1;        // Wraps at regionWords
        end
    end

    always_ff @(posedge rclk) begin
        if (pop) wordHold <= popData;       // Latched with the pop
    end

    // ======================================
    // Bus request
    // ======================================
    assign bus.cyc  = busy;
    assign bus.stb  = busy;                 // One transfer per cycle
    assign bus.we   = 1'b1;                 // Drain only writes
    assign bus.adr  = regionBase + ramAddrWidth'(offset);
    assign bus.datW = wordHold;

endmodule

`default_nettype wire

/* hdl/busArbiter.sv */
`default_nettype none
// ======================================
// Round robin, grant held while cyc high
// One idle cycle between two grants
// ======================================
module busArbiter (
    input  logic  rclk,     // Bus clock
    input  logic  arok,     // Async reset, active low
    wbBus.slave   bus0,     // Channel 0 drain
    wbBus.slave   bus1,     // Channel 1 drain
    wbBus.slave   busHost,  // Host port
    wbBus.master  ram       // To shared RAM
);
    import capturePkg::*;

    logic [numMasters-1:0]     reqCyc;      // cyc of every master
    logic [numMasters-1:0]     grant;       // One-hot or zero
    logic [masterIdxWidth-1:0] lastIdx;     // Last master granted
    logic [masterIdxWidth-1:0] pickIdx;     // Next winner
    logic                      pickValid;   // Some master requests

    assign reqCyc = {busHost.cyc, bus1.cyc, bus0.cyc};

    // ======================================
    // Selection
    // ======================================
    // Nearest requester after lastIdx wins, assigned last
    always_comb begin
        pickIdx   = lastIdx;
        pickValid = 1'b0;
        for (int i = numMasters; i >= 1; i--) begin
            if (reqCyc[(int'(lastIdx) + i) % numMasters]) begin
                pickIdx   = masterIdxWidth'((int'(lastIdx) + i) % numMasters);
                pickValid = 1'b1;
            end
        end
    end

    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            grant   <= '0;
            lastIdx <= masterIdxWidth'(numMasters - 1); // First search starts at 0
        end else if (grant == '0) begin
            if (pickValid) begin
                grant   <= numMasters'(1) << pickIdx;
                lastIdx <= pickIdx;
            end
        end else if ((grant & reqCyc) == '0) begin
            grant <= '0;                                // Winner dropped cyc
        end
    end

    // ======================================
    // Request mux and ack return
    // ======================================
    always_comb begin
        ram.cyc  = 1'b0;
        ram.stb  = 1'b0;
        ram.we   = 1'b0;
        ram.adr  = '0;
        ram.datW = '0;
        if (grant[0]) begin
            ram.cyc  = bus0.cyc;
            ram.stb  = bus0.stb;
            ram.we   = bus0.we;
            ram.adr  = bus0.adr;
            ram.datW = bus0.datW;
        end else if (grant[1]) begin
            ram.cyc  = bus1.cyc;
            ram.stb  = bus1.stb;
            ram.we   = bus1.we;
            ram.adr  = bus1.adr;
            ram.datW = bus1.datW;
        end else if (grant[2]) begin
            ram.cyc  = busHost.cyc;
            ram.stb  = busHost.stb;
            ram.we   = busHost.we;
            ram.adr  = busHost.adr;
            ram.datW = busHost.datW;
        end
    end

    assign bus0.ack     = grant[0] && ram.ack;    // Others see ack low
    assign bus1.ack     = grant[1] && ram.ack;
    assign busHost.ack  = grant[2] && ram.ack;
    assign bus0.datR    = grant[0] ? ram.datR : '0;
    assign bus1.datR    = grant[1] ? ram.datR : '0;
    assign busHost.datR = grant[2] ? ram.datR : '0;

endmodule

`default_nettype wire

/* hdl/sharedRam.sv */
`default_nettype none
// ======================================
// 64 x 16 RAM, ack one cycle after request
// ======================================
module sharedRam (
    input  logic  rclk,     // Bus clock
    input  logic  arok,     // Async reset, active low
    wbBus.slave   bus       // From arbiter
);
    import capturePkg::*;

    logic [dataWidth-1:0] mem [2**ramAddrWidth];   // Both regions
    logic [dataWidth-1:0] datRReg;                 // Registered read
    logic                 ackReg;                  // Single-cycle ack
    logic                 take;                    // Request seen this edge

    assign take = bus.cyc && bus.stb && !ackReg;  // Blocks a second ack

    // ======================================
    // Acknowledge
    // ======================================
    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) ackReg <= 1'b0;
        else       ackReg <= take;
    end

    // ======================================
    // Memory array
    // ======================================
    always_ff @(posedge rclk) begin
        if (take) begin
            if (bus.we) mem[bus.adr] <= bus.datW;  // Write with the ack edge
            datRReg <= mem[bus.adr];              // Old word on a write
        end
    end

    assign bus.ack  = ackReg;
    assign bus.datR = datRReg;                    // Valid together with ack

endmodule

`default_nettype wire

/* hdl/captureTop.sv */
`default_nettype none
// ======================================
// Two capture channels and host on one bus
// Host must follow Wishbone classic rules
// ======================================
module captureTop (
    input  logic                                rclk,       // Bus and drain clock
    input  logic                                wclk,       // Producer clock
    input  logic                                arok,       // Async reset, active low
    input  logic                                push0,      // Channel 0 producer
    input  logic [capturePkg::dataWidth-1:0]    pushData0,
    output logic                                pushOk0,
    input  logic                                push1,      // Channel 1 producer
    input  logic [capturePkg::dataWidth-1:0]    pushData1,
    output logic                                pushOk1,
    input  logic                                hostCyc,    // Host bus master
    input  logic                                hostStb,
    input  logic                                hostWe,
    input  logic [capturePkg::ramAddrWidth-1:0] hostAdr,
    input  logic [capturePkg::dataWidth-1:0]    hostDatW,
    output logic [capturePkg::dataWidth-1:0]    hostDatR,
    output logic                                hostAck
);
    import capturePkg::*;

    logic                 pop0;       // FIFO to drain, channel 0
    logic [dataWidth-1:0] popData0;
    logic                 popOk0;
    logic                 pop1;       // FIFO to drain, channel 1
    logic [dataWidth-1:0] popData1;
    logic                 popOk1;

    wbBus bus0();                     // Drain 0 to arbiter
    wbBus bus1();                     // Drain 1 to arbiter
    wbBus busHost();                  // Host to arbiter
    wbBus busRam();                   // Arbiter to RAM

    // ======================================
    // Host port
    // ======================================
    assign busHost.cyc  = hostCyc;
    assign busHost.stb  = hostStb;
    assign busHost.we   = hostWe;
    assign busHost.adr  = hostAdr;
    assign busHost.datW = hostDatW;
    assign hostDatR     = busHost.datR;
    assign hostAck      = busHost.ack;

    // ======================================
    // Capture channels
    // ======================================
    asyncFifo fifo0 (
        .wclk(wclk), .rclk(rclk), .arok(arok),
        .push(push0), .pushData(pushData0), .pushOk(pushOk0),
        .pop(pop0), .popData(popData0), .popOk(popOk0)
    );

    asyncFifo fifo1 (
        .wclk(wclk), .rclk(rclk), .arok(arok),
        .push(push1), .pushData(pushData1), .pushOk(pushOk1),
        .pop(pop1), .popData(popData1), .popOk(popOk1)
    );

    channelDrain #(.channelId(0)) drain0 (
        .rclk(rclk), .arok(arok),
        .popData(popData0), .popOk(popOk0), .pop(pop0),
        .bus(bus0)
    );

    channelDrain #(.channelId(1)) drain1 (
        .rclk(rclk), .arok(arok),
        .popData(popData1), .popOk(popOk1), .pop(pop1),
        .bus(bus1)
    );

    // ======================================
    // Shared bus
    // ======================================
    busArbiter arb0 (
        .rclk(rclk), .arok(arok),
        .bus0(bus0), .bus1(bus1), .busHost(busHost),
        .ram(busRam)
    );

    sharedRam ram0 (
        .rclk(rclk), .arok(arok),
        .bus(busRam)
    );

endmodule

`default_nettype wire

/* verif/captureTop_chk.sv */
`default_nettype none
// ======================================
// Bus checks, bound to arbiter and RAM
// Grant is tied to zero at the RAM side
// ======================================
module captureChk (
    input logic                                rclk,    // Bus clock
    input logic                                arok,    // Async reset, active low
    input logic [capturePkg::numMasters-1:0]   grant,   // Arbiter grant
    input logic                                cyc,     // Request seen by the RAM
    input logic                                stb,
    input logic                                we,
    input logic [capturePkg::ramAddrWidth-1:0] adr,
    input logic [capturePkg::dataWidth-1:0]    datW,
    input logic                                ack      // RAM acknowledge
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;                  // Failed assertions so far

    // ======================================
    // Arbiter
    // ======================================
    grantOneHot: assert property (@(posedge rclk) disable iff (!arok) $onehot0(grant))
        else begin
            failCount++;
            $error("Arbiter grant is neither one-hot nor zero");
        end

    // ======================================
    // Wishbone classic handshake
    // ======================================
    ackNeedsReq: assert property (@(posedge rclk) disable iff (!arok) ack |-> (cyc && stb))
        else begin
            failCount++;
            $error("ack seen without cyc and stb");
        end

    ackOneCycle: assert property (@(posedge rclk) disable iff (!arok) ack |=> !ack)
        else begin
            failCount++;
            $error("ack lasted longer than one cycle");
        end

    // Winning master keeps its request steady up to ack
    reqHeld: assert property (@(posedge rclk) disable iff (!arok)
        (cyc && stb && !ack) |=> (cyc && stb && $stable(we) && $stable(adr) && $stable(datW)))
        else begin
            failCount++;
            $error("Request changed or dropped before ack");
        end

endmodule

bind busArbiter captureChk chkArb (
    .rclk(rclk), .arok(arok), .grant(grant),
    .cyc(ram.cyc), .stb(ram.stb), .we(ram.we),
    .adr(ram.adr), .datW(ram.datW), .ack(ram.ack)
);

bind sharedRam captureChk chkRam (
    .rclk(rclk), .arok(arok), .grant('0),
    .cyc(bus.cyc), .stb(bus.stb), .we(bus.we),
    .adr(bus.adr), .datW(bus.datW), .ack(bus.ack)
);

`default_nettype wire

/* verif/captureTb.sv */
`default_nettype none
// ======================================
// Self-checking run of captureTop
// Random words from a fixed seed
// ======================================
module captureTb;
    timeunit 1ns;
    timeprecision 100ps;
    import capturePkg::*;

    logic                    rclk;
    logic                    wclk;
    logic                    arok;
    logic                    push0;
    logic [dataWidth-1:0]    pushData0;
    logic                    pushOk0;
    logic                    push1;
    logic [dataWidth-1:0]    pushData1;
    logic                    pushOk1;
    logic                    hostCyc;
    logic                    hostStb;
    logic                    hostWe;
    logic [ramAddrWidth-1:0] hostAdr;
    logic [dataWidth-1:0]    hostDatW;
    logic [dataWidth-1:0]    hostDatR;
    logic                    hostAck;

    int                      seed;
    int                      cycleCount;
    int                      timeoutCycles;
    int                      accepted;                 // Pushes taken under back-pressure
    logic [dataWidth-1:0]    word;
    logic [dataWidth-1:0]    readBack;

    // ======================================
    // Reference model of the RAM
    // ======================================
    logic [dataWidth-1:0]    expMem [2**ramAddrWidth];
    bit                      expSet [2**ramAddrWidth];  // Address holds a known word
    int                      pushCount [2];             // Running count per channel
    logic [ramAddrWidth+dataWidth-1:0] pending [2][$]; // {address, word} not yet checked

    captureTop dut0 (.*);

    initial begin
        rclk = 1'b0;
        forever #2 rclk = ~rclk;
    end

    initial begin
        wclk = 1'b0;
        forever #3 wclk = ~wclk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    // Expected slot is region base plus running count mod regionWords
    task automatic recordPush(input bit ch, input logic [dataWidth-1:0] data);
        logic [ramAddrWidth-1:0] addr;
        addr = ramAddrWidth'(ch * regionWords + pushCount[ch] % regionWords);
        pending[ch].push_back({addr, data});
        pushCount[ch]++;
    endtask

    // Single host transfer, cyc dropped one cycle after ack
    task automatic hostXfer(input logic we, input logic [ramAddrWidth-1:0] adr,
                            input logic [dataWidth-1:0] wdat,
                            output logic [dataWidth-1:0] rdat);
        @(negedge rclk);
        hostCyc  = 1'b1;
        hostStb  = 1'b1;
        hostWe   = we;
        hostAdr  = adr;
        hostDatW = wdat;
        do @(negedge rclk); while (!hostAck);
        rdat = hostDatR;                              // Valid with ack
        @(negedge rclk);
        hostCyc = 1'b0;
        hostStb = 1'b0;
        hostWe  = 1'b0;
    endtask

    task automatic checkWord(input string name, input logic [ramAddrWidth-1:0] adr,
                             input logic [dataWidth-1:0] exp);
        logic [dataWidth-1:0] got;
        hostXfer(1'b0, adr, '0, got);
        assert (got === exp) else
            reportFailure($sformatf("Error: %s address %0d expected %h actual %h",
                                    name, adr, exp, got));
    endtask

    task automatic checkAll(input string name);
        for (int a = 0; a < 2**ramAddrWidth; a++) begin
            if (expSet[a]) checkWord(name, ramAddrWidth'(a), expMem[a]);
        end
    endtask

    // Waits until the newest word of a channel shows in the RAM
    task automatic settleChannel(input bit ch);
        logic [ramAddrWidth+dataWidth-1:0] entry;
        logic [dataWidth-1:0]              got;
        if (pending[ch].size() > 0) begin
            entry = pending[ch][$];
            do hostXfer(1'b0, entry[ramAddrWidth+dataWidth-1:dataWidth], '0, got);
            while (got !== entry[dataWidth-1:0]);
            while (pending[ch].size() > 0) begin
                entry = pending[ch].pop_front();
                expMem[entry[ramAddrWidth+dataWidth-1:dataWidth]] = entry[dataWidth-1:0];
                expSet[entry[ramAddrWidth+dataWidth-1:dataWidth]] = 1'b1;
            end
        end
    endtask

    // Pushes only when pushOk, so every push is accepted
    task automatic pushWords(input int n0, input int n1);
        int left0;
        int left1;
        left0 = n0;
        left1 = n1;
        while (left0 > 0 || left1 > 0) begin
            @(negedge wclk);
            push0 = 1'b0;
            push1 = 1'b0;
            if (left0 > 0 && pushOk0) begin
                pushData0 = dataWidth'($random(seed));
                push0     = 1'b1;
                recordPush(1'b0, pushData0);
                left0--;
            end
            if (left1 > 0 && pushOk1) begin
                pushData1 = dataWidth'($random(seed));
                push1     = 1'b1;
                recordPush(1'b1, pushData1);
                left1--;
            end
        end
        @(negedge wclk);
        push0 = 1'b0;
        push1 = 1'b0;
    endtask

    // ======================================
    // Timeout
    // ======================================
    // About 3000 cycles of tests, doubled for margin
    initial begin
        cycleCount    = 0;
        timeoutCycles = 6000;
        while (cycleCount < timeoutCycles) begin
            @(posedge rclk);
            cycleCount++;
        end
        reportFailure($sformatf("Timeout: run not done after %0d rclk cycles", timeoutCycles));
    end

    // Bound checker failures end the run at once
    always @(negedge rclk) begin
        if (dut0.arb0.chkArb.failCount + dut0.ram0.chkRam.failCount != 0)
            reportFailure("A bound bus protocol assertion failed");
    end

    // ======================================
    // Tests
    // ======================================
    initial begin
        seed      = 32'h911c_1ec7;
        arok      = 1'b0;
        push0     = 1'b0;
        pushData0 = '0;
        push1     = 1'b0;
        pushData1 = '0;
        hostCyc   = 1'b0;
        hostStb   = 1'b0;
        hostWe    = 1'b0;
        hostAdr   = '0;
        hostDatW  = '0;
        repeat (16) @(posedge rclk);
        @(negedge rclk);
        arok = 1'b1;

        // Reset state, before any clock edge acts on it
        assert (pushOk0 && pushOk1) else reportFailure("pushOk is not high after reset");
        assert (!hostAck) else reportFailure("hostAck is high after reset");

        pushWords(20, 0);                             // Lands at 0 to 19
        settleChannel(1'b0);
        checkAll("orderedCapture");

        pushWords(12, 12);                            // Both drains compete
        settleChannel(1'b0);
        settleChannel(1'b1);
        checkAll("twoChannels");

        pushWords(0, 40);                             // Last 32 words fill region 1
        settleChannel(1'b1);
        checkAll("wrap");

        @(negedge rclk);
        hostCyc = 1'b1;                               // Hold the bus, no transfer
        repeat (4) @(negedge rclk);
        accepted = 0;
        repeat (40) begin
            @(negedge wclk);
            push0 = 1'b0;
            if (pushOk0) begin
                pushData0 = dataWidth'($random(seed));
                push0     = 1'b1;
                recordPush(1'b0, pushData0);
                accepted++;
            end
        end
        @(negedge wclk);
        push0 = 1'b0;
        assert (accepted <= fifoDepth + 1) else
            reportFailure($sformatf("Error: backPressure pushes expected at most %0d actual %0d",
                                    fifoDepth + 1, accepted));
        assert (!pushOk0) else reportFailure("pushOk0 stayed high while the host held the bus");
        @(negedge rclk);
        hostCyc = 1'b0;
        settleChannel(1'b0);
        checkAll("backPressure");

        word = dataWidth'($random(seed));
        hostXfer(1'b1, ramAddrWidth'(45), word, readBack);
        expMem[45] = word;                            // Host now owns this slot
        checkWord("hostWrite", ramAddrWidth'(45), word);

        if (dut0.arb0.chkArb.failCount + dut0.ram0.chkRam.failCount == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            reportFailure("A bound bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/capturePkg.sv
hdl/wbBus.sv
hdl/asyncFifo.sv
hdl/channelDrain.sv
hdl/busArbiter.sv
hdl/sharedRam.sv
hdl/captureTop.sv
verif/captureTop_chk.sv
verif/captureTb.sv

/* Makefile */
# Verilator build and run of the capture buffer testbench

VERILATOR ?= verilator
TOP       ?= captureTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+100

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Result: no verdict"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
